/* verilog/riscv_pkg.sv */
// --------------------------------------------------------------------------
// riscv pipeline shared definitions
// widths, instruction encodings, ALU operations and forward selects
// --------------------------------------------------------------------------
package riscv_pkg;

    localparam int xlen        = 32;
    localparam int num_regs    = 32;
    localparam int reg_addr_w  = 5;
    localparam int word_addr_w = 30;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    typedef enum logic [6:0] {
        op_r_type = 7'b0110011,
        op_i_type = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_nop = 4'd0,
        alu_add = 4'd1,
        alu_sub = 4'd2,
        alu_and = 4'd3,
        alu_or  = 4'd4,
        alu_xor = 4'd5,
        alu_sll = 4'd6,
        alu_sra = 4'd7,
        alu_srl = 4'd8,
        alu_slt = 4'd9
    } alu_op_e;

    // register value, memory-stage ALU result or write-back data
    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_e;

    // caches are big endian, the core is little endian
    function automatic logic [xlen-1:0] byte_swap(input logic [xlen-1:0] word);
        return {<<8{word}};
    endfunction

endpackage

/* verilog/fetch_stage.sv */
// --------------------------------------------------------------------------
// fetch stage
// word program counter, instruction byte swap and the fetch/decode register
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module fetch_stage import riscv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [xlen-1:0]        icache_rdata,
    input  logic                   front_stall,
    input  logic                   stall_all,
    input  logic                   branch_taken,
    input  logic [word_addr_w-1:0] branch_target,
    output logic [word_addr_w-1:0] icache_addr,
    output logic [xlen-1:0]        id_instr,
    output logic [word_addr_w-1:0] id_pc
);

    logic [word_addr_w-1:0] pc;
    logic                   hold;

    assign hold        = stall_all | front_stall;
    assign icache_addr = pc;

    // pc and the instruction word, a taken branch squashes the fetched slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= '0;
            id_instr <= nop_instr;
        end else if (!hold) begin
            if (branch_taken) begin
                pc       <= branch_target;
                id_instr <= nop_instr;
            end else begin
                pc       <= pc + 1'b1;
                id_instr <= byte_swap(icache_rdata);
            end
        end
    end

    // address travels with the instruction for the branch target
    always_ff @(posedge clk) begin
        if (!hold) begin
            id_pc <= pc;
        end
    end

endmodule

/* verilog/reg_file.sv */
// --------------------------------------------------------------------------
// register file
// 31 writable registers, x0 reads zero, writes pass through to both readers
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module reg_file import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    input  logic                  wb_en,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data
);

    logic [xlen-1:0] regs [1:num_regs-1];

    // x0 reads zero, a write in the same cycle returns the new value
    assign rs1_data = (rs1_addr == '0)             ? '0      :
                      (wb_en && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0)             ? '0      :
                      (wb_en && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

    // no writes while in reset
    always_ff @(posedge clk) begin
        if (rst_n && wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

/* verilog/decode_stage.sv */
// --------------------------------------------------------------------------
// decode stage
// field decode, ALU operation, immediates and branch resolution
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module decode_stage import riscv_pkg::*; (
    input  logic [xlen-1:0]        id_instr,
    input  logic [word_addr_w-1:0] id_pc,
    input  logic [xlen-1:0]        rs1_data,
    input  logic [xlen-1:0]        rs2_data,
    input  fwd_sel_e               br_fwd_a,
    input  fwd_sel_e               br_fwd_b,
    input  logic [xlen-1:0]        mem_alu_out,
    input  logic                   branch_stall,
    output logic [reg_addr_w-1:0]  rs1,
    output logic [reg_addr_w-1:0]  rs2,
    output logic [reg_addr_w-1:0]  rd,
    output opcode_e                opcode,
    output alu_op_e                alu_op,
    output logic                   reg_write,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic [xlen-1:0]        imm,
    output logic                   branch_taken,
    output logic [word_addr_w-1:0] branch_target
);

    logic [2:0]      func3;
    logic            is_beq;
    logic            is_bne;
    logic [xlen-1:0] cmp_a;
    logic [xlen-1:0] cmp_b;

    assign opcode = opcode_e'(id_instr[6:0]);
    assign func3  = id_instr[14:12];
    assign rs1    = id_instr[19:15];
    assign rs2    = id_instr[24:20];
    assign rd     = id_instr[11:7];

    assign reg_write = opcode inside {op_r_type, op_i_type, op_load};
    assign mem_read  = (opcode == op_load);
    assign mem_write = (opcode == op_store);
    assign is_beq    = (opcode == op_branch) && (func3 == 3'b000);
    assign is_bne    = (opcode == op_branch) && (func3 == 3'b001);

    // ALU operation from opcode, func3 and bit 30
    always_comb begin
        alu_op = alu_nop;
        if (opcode == op_r_type) begin
            case (func3)
                3'b000:  alu_op = id_instr[30] ? alu_sub : alu_add;
                3'b010:  alu_op = alu_slt;
                3'b100:  alu_op = alu_xor;
                3'b110:  alu_op = alu_or;
                3'b111:  alu_op = alu_and;
                default: alu_op = alu_nop;
            endcase
        end else if (opcode == op_i_type) begin
            case (func3)
                3'b000:  alu_op = alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = id_instr[30] ? alu_sra : alu_srl;
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end else if (mem_read || mem_write) begin
            alu_op = alu_add;
        end
    end

    // immediate generation
    always_comb begin
        if (opcode == op_branch) begin
            imm = {{20{id_instr[31]}}, id_instr[7], id_instr[30:25], id_instr[11:8], 1'b0};
        end else if (mem_write) begin
            imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
        end else if (opcode == op_i_type && func3[1:0] == 2'b01) begin
            // shift amount only
            imm = {27'd0, id_instr[24:20]};
        end else begin
            imm = {{20{id_instr[31]}}, id_instr[31:20]};
        end
    end

    // branch compare, write-back values already come through the reg file
    assign cmp_a = (br_fwd_a == fwd_mem) ? mem_alu_out : rs1_data;
    assign cmp_b = (br_fwd_b == fwd_mem) ? mem_alu_out : rs2_data;

    assign branch_taken  = !branch_stall &&
                           ((is_beq && cmp_a == cmp_b) || (is_bne && cmp_a != cmp_b));
    assign branch_target = id_pc + imm[word_addr_w+1:2];

endmodule

/* verilog/hazard_unit.sv */
// --------------------------------------------------------------------------
// hazard unit
// load-use and branch-operand stalls, forward selects for decode and execute
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module hazard_unit import riscv_pkg::*; (
    input  opcode_e               opcode,
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic                  ex_reg_write,
    input  logic                  ex_mem_read,
    input  logic [reg_addr_w-1:0] mem_rd,
    input  logic                  mem_reg_write,
    input  logic                  mem_mem_read,
    input  logic                  icache_stall,
    output logic                  load_use_stall,
    output logic                  branch_stall,
    output logic                  front_stall,
    output fwd_sel_e              br_fwd_a,
    output fwd_sel_e              br_fwd_b,
    output fwd_sel_e              ex_fwd_a,
    output fwd_sel_e              ex_fwd_b
);

    logic uses_rs1;
    logic uses_rs2;
    logic is_branch;
    logic ex_hit_a;
    logic ex_hit_b;
    logic mem_hit_a;
    logic mem_hit_b;

    assign is_branch = (opcode == op_branch);
    assign uses_rs1  = opcode inside {op_r_type, op_i_type, op_load, op_store, op_branch};
    assign uses_rs2  = opcode inside {op_r_type, op_store, op_branch};

    // producer matches, destination x0 never counts
    assign ex_hit_a  = uses_rs1 && ex_reg_write && ex_rd != '0 && ex_rd == rs1;
    assign ex_hit_b  = uses_rs2 && ex_reg_write && ex_rd != '0 && ex_rd == rs2;
    assign mem_hit_a = uses_rs1 && mem_reg_write && mem_rd != '0 && mem_rd == rs1;
    assign mem_hit_b = uses_rs2 && mem_reg_write && mem_rd != '0 && mem_rd == rs2;

    assign load_use_stall = ex_mem_read && (ex_hit_a || ex_hit_b);

    // branches compare in decode, so execute results and loads in memory are too late
    assign branch_stall = is_branch &&
                          (ex_hit_a || ex_hit_b || (mem_mem_read && (mem_hit_a || mem_hit_b)));

    assign front_stall = icache_stall | load_use_stall | branch_stall;

    assign br_fwd_a = mem_hit_a ? fwd_mem : fwd_none;
    assign br_fwd_b = mem_hit_b ? fwd_mem : fwd_none;

    // seen from execute one cycle later, today's execute is then in memory
    assign ex_fwd_a = ex_hit_a ? fwd_mem : (mem_hit_a ? fwd_wb : fwd_none);
    assign ex_fwd_b = ex_hit_b ? fwd_mem : (mem_hit_b ? fwd_wb : fwd_none);

endmodule

/* verilog/execute_stage.sv */
// --------------------------------------------------------------------------
// execute stage
// decode/execute register, operand forwarding, ALU, execute/memory register
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module execute_stage import riscv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall_all,
    input  logic                  bubble,
    input  alu_op_e               alu_op,
    input  logic [xlen-1:0]       operand_a,
    input  logic [xlen-1:0]       operand_b,
    input  logic [xlen-1:0]       store_data,
    input  logic [reg_addr_w-1:0] rd,
    input  logic                  reg_write,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  fwd_sel_e              fwd_a,
    input  fwd_sel_e              fwd_b,
    input  fwd_sel_e              fwd_store,
    input  logic [xlen-1:0]       wb_data,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic                  ex_reg_write,
    output logic                  ex_mem_read,
    output logic [xlen-1:0]       mem_alu_out,
    output logic [xlen-1:0]       mem_store_data,
    output logic [reg_addr_w-1:0] mem_rd,
    output logic                  mem_reg_write,
    output logic                  mem_mem_read,
    output logic                  mem_mem_write
);

    alu_op_e         ex_alu_op;
    logic            ex_mem_write;
    fwd_sel_e        ex_fwd_a;
    fwd_sel_e        ex_fwd_b;
    fwd_sel_e        ex_fwd_store;
    logic [xlen-1:0] ex_op_a;
    logic [xlen-1:0] ex_op_b;
    logic [xlen-1:0] ex_store;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] fwd_store_data;
    logic [xlen-1:0] sub_result;
    logic [xlen-1:0] alu_out;

    // --------------------------------------------------------------------------
    // decode/execute register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_alu_op    <= alu_nop;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_fwd_a     <= fwd_none;
            ex_fwd_b     <= fwd_none;
            ex_fwd_store <= fwd_none;
        end else if (!stall_all) begin
            ex_alu_op    <= bubble ? alu_nop : alu_op;
            ex_reg_write <= reg_write & ~bubble;
            ex_mem_read  <= mem_read & ~bubble;
            ex_mem_write <= mem_write & ~bubble;
            ex_fwd_a     <= bubble ? fwd_none : fwd_a;
            ex_fwd_b     <= bubble ? fwd_none : fwd_b;
            ex_fwd_store <= bubble ? fwd_none : fwd_store;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_all) begin
            ex_rd    <= rd;
            ex_op_a  <= operand_a;
            ex_op_b  <= operand_b;
            ex_store <= store_data;
        end
    end

    // --------------------------------------------------------------------------
    // forwarding and ALU

    function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_e        sel,
                                                input logic [xlen-1:0] reg_val,
                                                input logic [xlen-1:0] mem_val,
                                                input logic [xlen-1:0] wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign alu_a          = fwd_mux(ex_fwd_a, ex_op_a, mem_alu_out, wb_data);
    assign alu_b          = fwd_mux(ex_fwd_b, ex_op_b, mem_alu_out, wb_data);
    assign fwd_store_data = fwd_mux(ex_fwd_store, ex_store, mem_alu_out, wb_data);
    assign sub_result     = alu_a - alu_b;

    always_comb begin
        case (ex_alu_op)
            alu_add: alu_out = alu_a + alu_b;
            alu_sub: alu_out = sub_result;
            alu_and: alu_out = alu_a & alu_b;
            alu_or:  alu_out = alu_a | alu_b;
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_sll: alu_out = alu_a << alu_b[4:0];
            alu_sra: alu_out = $signed(alu_a) >>> alu_b[4:0];
            alu_srl: alu_out = alu_a >> alu_b[4:0];
            // sign of the difference
            alu_slt: alu_out = {{(xlen-1){1'b0}}, sub_result[xlen-1]};
            default: alu_out = '0;
        endcase
    end

    // --------------------------------------------------------------------------
    // execute/memory register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else if (!stall_all) begin
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_all) begin
            mem_rd         <= ex_rd;
            mem_alu_out    <= alu_out;
            mem_store_data <= fwd_store_data;
        end
    end

endmodule

/* verilog/mem_wb_stage.sv */
// --------------------------------------------------------------------------
// memory stage
// data cache request, load data select and the memory/write-back register
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module mem_wb_stage import riscv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall_all,
    input  logic [xlen-1:0]        mem_alu_out,
    input  logic [xlen-1:0]        mem_store_data,
    input  logic [reg_addr_w-1:0]  mem_rd,
    input  logic                   mem_reg_write,
    input  logic                   mem_mem_read,
    input  logic                   mem_mem_write,
    input  logic [xlen-1:0]        dcache_rdata,
    output logic                   dcache_ren,
    output logic                   dcache_wen,
    output logic [word_addr_w-1:0] dcache_addr,
    output logic [xlen-1:0]        dcache_wdata,
    output logic                   wb_en,
    output logic [reg_addr_w-1:0]  wb_rd,
    output logic [xlen-1:0]        wb_data
);

    assign dcache_ren   = mem_mem_read;
    assign dcache_wen   = mem_mem_write;
    assign dcache_addr  = mem_alu_out[word_addr_w+1:2];
    assign dcache_wdata = byte_swap(mem_store_data);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else if (!stall_all) begin
            wb_en <= mem_reg_write && mem_rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_all) begin
            wb_rd   <= mem_rd;
            wb_data <= mem_mem_read ? byte_swap(dcache_rdata) : mem_alu_out;
        end
    end

endmodule

/* verilog/riscv_pipeline.sv */
// --------------------------------------------------------------------------
// five-stage RISC-V integer pipeline
// fetch, decode, execute, memory and write-back with cache ports
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module riscv_pipeline import riscv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [xlen-1:0]        icache_rdata,
    input  logic                   icache_stall,
    input  logic [xlen-1:0]        dcache_rdata,
    input  logic                   dcache_stall,
    output logic [word_addr_w-1:0] icache_addr,
    output logic                   dcache_ren,
    output logic                   dcache_wen,
    output logic [word_addr_w-1:0] dcache_addr,
    output logic [xlen-1:0]        dcache_wdata
);

    logic [xlen-1:0]        id_instr;
    logic [word_addr_w-1:0] id_pc;
    logic [reg_addr_w-1:0]  rs1, rs2, rd;
    opcode_e                opcode;
    alu_op_e                alu_op;
    logic                   reg_write, mem_read, mem_write;
    logic [xlen-1:0]        imm, rs1_data, rs2_data, operand_b;
    logic                   branch_taken, branch_stall, front_stall;
    logic [word_addr_w-1:0] branch_target;
    fwd_sel_e               br_fwd_a, br_fwd_b, ex_fwd_a, ex_fwd_b, fwd_b;
    logic [reg_addr_w-1:0]  ex_rd, mem_rd, wb_rd;
    logic                   ex_reg_write, ex_mem_read;
    logic                   mem_reg_write, mem_mem_read, mem_mem_write;
    logic [xlen-1:0]        mem_alu_out, mem_store_data, wb_data;
    logic                   wb_en;

    // only R-type takes rs2 into the ALU, stores carry it as data
    assign operand_b = (opcode == op_r_type) ? rs2_data : imm;
    assign fwd_b     = (opcode == op_r_type) ? ex_fwd_b : fwd_none;

    fetch_stage fetch_i (
        .clk, .rst_n, .icache_rdata, .front_stall, .stall_all (dcache_stall),
        .branch_taken, .branch_target, .icache_addr, .id_instr, .id_pc
    );

    reg_file reg_file_i (
        .clk, .rst_n, .rs1_addr (rs1), .rs2_addr (rs2), .wb_en, .wb_rd, .wb_data,
        .rs1_data, .rs2_data
    );

    decode_stage decode_i (
        .id_instr, .id_pc, .rs1_data, .rs2_data, .br_fwd_a, .br_fwd_b, .mem_alu_out,
        .branch_stall, .rs1, .rs2, .rd, .opcode, .alu_op, .reg_write, .mem_read,
        .mem_write, .imm, .branch_taken, .branch_target
    );

    hazard_unit hazard_i (
        .opcode, .rs1, .rs2, .ex_rd, .ex_reg_write, .ex_mem_read, .mem_rd,
        .mem_reg_write, .mem_mem_read, .icache_stall, .load_use_stall (),
        .branch_stall, .front_stall, .br_fwd_a, .br_fwd_b, .ex_fwd_a, .ex_fwd_b
    );

    execute_stage execute_i (
        .clk, .rst_n, .stall_all (dcache_stall), .bubble (front_stall), .alu_op,
        .operand_a (rs1_data), .operand_b, .store_data (rs2_data), .rd, .reg_write,
        .mem_read, .mem_write, .fwd_a (ex_fwd_a), .fwd_b, .fwd_store (ex_fwd_b),
        .wb_data, .ex_rd, .ex_reg_write, .ex_mem_read, .mem_alu_out, .mem_store_data,
        .mem_rd, .mem_reg_write, .mem_mem_read, .mem_mem_write
    );

    mem_wb_stage mem_wb_i (
        .clk, .rst_n, .stall_all (dcache_stall), .mem_alu_out, .mem_store_data,
        .mem_rd, .mem_reg_write, .mem_mem_read, .mem_mem_write, .dcache_rdata,
        .dcache_ren, .dcache_wen, .dcache_addr, .dcache_wdata, .wb_en, .wb_rd, .wb_data
    );

endmodule

/* dv/riscv_pipeline_tb.sv */
// --------------------------------------------------------------------------
// testbench for the five-stage RISC-V pipeline
// cache models with random stalls, a fixed program and store stream checks
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module riscv_pipeline_tb import riscv_pkg::*; ();

    localparam int reset_cycles   = 16;
    localparam int prog_len       = 45;
    localparam int timeout_cycles = reset_cycles + 200 * prog_len;

    // data stored only from slots that a taken branch skips
    localparam logic [xlen-1:0] marker = 32'h0000_07ad;

    logic                   clk;
    logic                   rst_n;
    logic [word_addr_w-1:0] icache_addr;
    logic [xlen-1:0]        icache_rdata;
    logic                   icache_stall;
    logic                   dcache_ren;
    logic                   dcache_wen;
    logic [word_addr_w-1:0] dcache_addr;
    logic [xlen-1:0]        dcache_wdata;
    logic [xlen-1:0]        dcache_rdata;
    logic                   dcache_stall;

    logic [xlen-1:0]        prog [0:63];
    logic [xlen-1:0]        dmem [0:63];
    logic [word_addr_w-1:0] exp_addr [$];
    logic [xlen-1:0]        exp_data [$];
    int                     store_idx = 0;
    int                     edge_count = 0;
    logic                   all_stores_seen = 1'b0;
    int unsigned            rand_seed = 32'ha1f8_b5f2;

    // data cache request of the previous cycle
    logic                   stall_q = 1'b0;
    logic                   ren_q;
    logic                   wen_q;
    logic [word_addr_w-1:0] addr_q;
    logic [xlen-1:0]        wdata_q;

    riscv_pipeline dut_i (
        .clk, .rst_n, .icache_rdata, .icache_stall, .dcache_rdata, .dcache_stall,
        .icache_addr, .dcache_ren, .dcache_wen, .dcache_addr, .dcache_wdata
    );

    // --------------------------------------------------------------------------
    // instruction encoding and helpers

    function automatic logic [31:0] r_instr(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_instr(input logic [2:0] f3, input int rd,
                                              input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] load_instr(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] store_instr(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_instr(input logic [2:0] f3, input int rs1,
                                                 input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] swap_bytes(input logic [31:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic expect_store(input logic [word_addr_w-1:0] word,
                                input logic [xlen-1:0] data);
        exp_addr.push_back(word);
        exp_data.push_back(data);
    endtask

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            prog[i] = 32'h0000_0013;
        end
        // dependent ALU chain
        prog[0]  = imm_instr(3'b000, 1, 0, 100);
        prog[1]  = imm_instr(3'b000, 2, 0, -7);
        prog[2]  = r_instr(7'b0000000, 3'b000, 3, 1, 2);
        prog[3]  = r_instr(7'b0100000, 3'b000, 4, 3, 1);
        prog[4]  = store_instr(4, 0, 0);
        prog[5]  = r_instr(7'b0000000, 3'b010, 5, 4, 1);
        prog[6]  = imm_instr(3'b010, 6, 4, -3);
        prog[7]  = r_instr(7'b0000000, 3'b010, 7, 1, 4);
        prog[8]  = r_instr(7'b0000000, 3'b100, 8, 3, 4);
        prog[9]  = r_instr(7'b0000000, 3'b110, 9, 8, 5);
        prog[10] = r_instr(7'b0000000, 3'b111, 10, 9, 3);
        prog[11] = store_instr(5, 0, 4);
        prog[12] = store_instr(6, 0, 8);
        prog[13] = store_instr(7, 0, 12);
        prog[14] = store_instr(8, 0, 16);
        prog[15] = store_instr(10, 0, 20);
        // shifts, srai against srli on a negative value
        prog[16] = imm_instr(3'b001, 11, 10, 29);
        prog[17] = imm_instr(3'b101, 12, 11, 32'h404);
        prog[18] = imm_instr(3'b101, 13, 11, 4);
        prog[19] = imm_instr(3'b100, 14, 12, -1);
        prog[20] = imm_instr(3'b110, 15, 13, 32'h123);
        prog[21] = imm_instr(3'b111, 16, 14, -256);
        prog[22] = store_instr(12, 0, 24);
        prog[23] = store_instr(13, 0, 28);
        prog[24] = store_instr(15, 0, 32);
        prog[25] = store_instr(16, 0, 36);
        // load-use
        prog[26] = load_instr(17, 0, 160);
        prog[27] = r_instr(7'b0000000, 3'b000, 18, 17, 1);
        prog[28] = store_instr(18, 0, 40);
        // x0 stays zero
        prog[29] = imm_instr(3'b000, 0, 0, 55);
        prog[30] = store_instr(0, 0, 44);
        // branches on fresh ALU results and fresh loads
        prog[31] = imm_instr(3'b000, 31, 0, 32'h7ad);
        prog[32] = imm_instr(3'b000, 19, 0, 5);
        prog[33] = branch_instr(3'b000, 19, 10, 8);
        prog[34] = store_instr(31, 0, 64);
        prog[35] = imm_instr(3'b000, 20, 0, 5);
        prog[36] = branch_instr(3'b001, 20, 10, 8);
        prog[37] = store_instr(20, 0, 48);
        prog[38] = load_instr(21, 0, 164);
        prog[39] = branch_instr(3'b001, 21, 17, 8);
        prog[40] = store_instr(31, 0, 68);
        prog[41] = load_instr(22, 0, 160);
        prog[42] = branch_instr(3'b000, 22, 18, 8);
        prog[43] = store_instr(22, 0, 52);
        prog[44] = branch_instr(3'b000, 0, 0, 0);
    endtask

    // cache words are big endian, core value {5a, index, c3, ~index}
    task automatic load_data();
        logic [7:0] idx;
        for (int i = 0; i < 64; i++) begin
            idx = 8'(i);
            dmem[i] = swap_bytes({8'h5a, idx, 8'hc3, ~idx});
        end
    endtask

    task automatic load_expected_stores();
        expect_store(0, 32'hffff_fff9);
        expect_store(1, 32'h0000_0001);
        expect_store(2, 32'h0000_0001);
        expect_store(3, 32'h0000_0000);
        expect_store(4, 32'hffff_ffa4);
        expect_store(5, 32'h0000_0005);
        expect_store(6, 32'hfa00_0000);
        expect_store(7, 32'h0a00_0000);
        expect_store(8, 32'h0a00_0123);
        expect_store(9, 32'h05ff_ff00);
        expect_store(10, 32'h5a28_c43b);
        expect_store(11, 32'h0000_0000);
        expect_store(12, 32'h0000_0005);
        expect_store(13, 32'h5a28_c3d7);
    endtask

    // --------------------------------------------------------------------------
    // clock, reset, cache models

    assign icache_rdata = swap_bytes(prog[icache_addr[5:0]]);
    assign dcache_rdata = dmem[dcache_addr[5:0]];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random stalls on both caches once reset is released
    initial begin
        icache_stall = 1'b0;
        dcache_stall = 1'b0;
        void'($urandom(rand_seed));
        forever begin
            @(posedge clk);
            if (rst_n) begin
                icache_stall <= ($urandom % 4) == 0;
                dcache_stall <= ($urandom % 4) == 0;
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        load_program();
        load_data();
        load_expected_stores();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        wait (all_stores_seen);
        $display(">>> PASS");
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired, the program did not finish in %0d cycles", timeout_cycles);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    end

    // --------------------------------------------------------------------------
    // checks

    // quiet outputs through reset and in the first cycle after it
    always @(posedge clk) begin
        if (edge_count >= 1 && edge_count <= reset_cycles) begin
            assert (icache_addr === '0 && dcache_ren === 1'b0 && dcache_wen === 1'b0)
                else report_failure("cache request active during or right after reset");
        end
        edge_count <= edge_count + 1;
    end

    always @(posedge clk) begin
        logic [xlen-1:0] data;
        if (stall_q) begin
            assert (dcache_ren === ren_q && dcache_wen === wen_q &&
                    dcache_addr === addr_q && dcache_wdata === wdata_q)
                else report_failure("data cache request changed while stalled");
        end
        stall_q <= dcache_stall;
        ren_q   <= dcache_ren;
        wen_q   <= dcache_wen;
        addr_q  <= dcache_addr;
        wdata_q <= dcache_wdata;

        // a store is taken in the cycle its stall is low
        if (dcache_wen === 1'b1 && !dcache_stall) begin
            data = swap_bytes(dcache_wdata);
            dmem[dcache_addr[5:0]] <= dcache_wdata;
            assert (data !== marker)
                else report_failure("store from a skipped branch slot was executed");
            assert (store_idx < exp_addr.size())
                else report_failure("more stores than expected");
            assert (dcache_addr === exp_addr[store_idx] && data === exp_data[store_idx])
                else report_failure($sformatf("store %0d to word %0h data %08h, expected %0h %08h",
                                              store_idx, dcache_addr, data,
                                              exp_addr[store_idx], exp_data[store_idx]));
            store_idx++;
            if (store_idx == exp_addr.size()) begin
                all_stores_seen = 1'b1;
            end
        end
    end

endmodule

/* project.f */
verilog/riscv_pkg.sv
verilog/fetch_stage.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/riscv_pipeline.sv
dv/riscv_pipeline_tb.sv

/* Bender.yml */
package:
  name: riscv_pipeline

sources:
  - files:
      - verilog/riscv_pkg.sv
      - verilog/fetch_stage.sv
      - verilog/reg_file.sv
      - verilog/decode_stage.sv
      - verilog/hazard_unit.sv
      - verilog/execute_stage.sv
      - verilog/mem_wb_stage.sv
      - verilog/riscv_pipeline.sv
  - target: test
    files:
      - dv/riscv_pipeline_tb.sv
